//--- logic/pdu_defines.svh
`ifndef PDU_DEFINES_SVH
`define PDU_DEFINES_SVH

// Flit data width and its byte count.
`define FLIT_W 128
`define FLIT_BYTES 16

// Width of the empty-byte count on the eop flit.
`define EMPTY_W ($clog2(`FLIT_BYTES))

// Ring of 64 slots.
`define RING_AW 6

// Largest PDU in slots, header included.
`define MAX_PDU_FLITS 9

// Header field widths.
`define TUPLE_W 96
`define PDU_LEN_W 8
`define PDU_ID_W 8

// Host address bits that still fit in the header flit.
`define HOST_HDR_W (`FLIT_W - `PDU_LEN_W - `PDU_ID_W - `TUPLE_W)

`endif

//--- logic/pdu_pkg.sv
`include "pdu_defines.svh"

package pdu_pkg;

    typedef struct packed {
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } tuple_t;

    typedef struct packed {
        tuple_t      tuple;
        logic [31:0] host_addr;
    } meta_t;

    // One flit wide; host address holds the low bits only.
    typedef struct packed {
        logic [`PDU_LEN_W-1:0]  byte_len;
        logic [`PDU_ID_W-1:0]   pdu_id;
        tuple_t                 tuple;
        logic [`HOST_HDR_W-1:0] host_addr;
    } pdu_hdr_t;

    // Ring word. sop marks the header, eop the last data flit.
    typedef struct packed {
        logic               sop;
        logic               eop;
        logic [`FLIT_W-1:0] data;
    } flit_t;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        HEAD,
        HOLD
    } gen_state_t;

endpackage

//--- logic/ring_mem.sv
`timescale 1ns/1ns
`include "pdu_defines.svh"

module ring_mem (
    input  logic                clk,
    input  logic                wr_en,
    input  logic [`RING_AW-1:0] wr_addr,
    input  pdu_pkg::flit_t      wr_flit,
    input  logic [`RING_AW-1:0] rd_addr,
    output pdu_pkg::flit_t      rd_flit
);
    import pdu_pkg::*;

    localparam int DEPTH = 1 << `RING_AW;

    flit_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_flit;
        end
    end

    // Host read port, one cycle latency.
    always_ff @(posedge clk) begin
        rd_flit <= mem[rd_addr];
    end

endmodule

//--- logic/ring_ctrl.sv
`timescale 1ns/1ns
`include "pdu_defines.svh"

module ring_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                update_valid,
    input  logic [`RING_AW-1:0] update_size,
    output logic [`RING_AW-1:0] base_addr,
    output logic                base_valid,
    output logic                almost_full,
    input  logic                free_req,
    input  logic [`RING_AW:0]   free_count,
    output logic                free_ack
);

    localparam int CNT_W = `RING_AW + 1;
    localparam int DEPTH = 1 << `RING_AW;

    logic [`RING_AW-1:0] tail;
    logic [CNT_W-1:0]    free_slots;
    logic [CNT_W-1:0]    free_next;
    logic                free_take;

    assign base_addr = tail;

    // New request only once the previous ack is gone.
    assign free_take = free_req && !free_ack;

    // Update and free may land on the same cycle.
    always_comb begin
        free_next = free_slots;
        if (update_valid) begin
            free_next = free_next - {1'b0, update_size};
        end
        if (free_take) begin
            free_next = free_next + free_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail        <= '0;
            free_slots  <= CNT_W'(DEPTH);
            base_valid  <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            free_slots  <= free_next;
            almost_full <= (free_next < CNT_W'(`MAX_PDU_FLITS));
            if (update_valid) begin
                tail       <= tail + update_size;
                base_valid <= 1'b0;
            end else begin
                base_valid <= 1'b1;
            end
        end
    end

    // Four-phase free exchange.
    always_ff @(posedge clk) begin
        if (rst) begin
            free_ack <= 1'b0;
        end else if (free_take) begin
            free_ack <= 1'b1;
        end else if (!free_req) begin
            free_ack <= 1'b0;
        end
    end

endmodule

//--- logic/pdu_gen.sv
`timescale 1ns/1ns
`include "pdu_defines.svh"

module pdu_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 in_sop,
    input  logic                 in_eop,
    input  logic [`FLIT_W-1:0]   in_data,
    input  logic [`EMPTY_W-1:0]  in_empty,
    output logic                 in_ready,
    input  logic                 meta_valid,
    input  pdu_pkg::meta_t       meta,
    output logic                 meta_ready,
    input  logic [`RING_AW-1:0]  base_addr,
    input  logic                 base_valid,
    input  logic                 almost_full,
    output logic                 wr_en,
    output logic [`RING_AW-1:0]  wr_addr,
    output pdu_pkg::flit_t       wr_flit,
    output logic                 update_valid,
    output logic [`RING_AW-1:0]  update_size
);
    import pdu_pkg::*;

    localparam int LEN_W  = `PDU_LEN_W;
    localparam int HOST_W = `HOST_HDR_W;
    localparam logic [`RING_AW-1:0] RING_AW_ONE = `RING_AW'(1);

    gen_state_t state;

    // PDU accounting.
    logic [`RING_AW-1:0]  flit_cnt;
    logic [LEN_W-1:0]     byte_cnt;
    logic [LEN_W-1:0]     flit_len;
    logic [`PDU_ID_W-1:0] pdu_id;
    pdu_hdr_t             hdr;

    // First pipeline stage.
    logic                 s1_wr;
    logic                 s1_swap;
    logic                 s1_sop;
    logic                 s1_eop;
    logic [`RING_AW-1:0]  s1_addr;
    logic [`FLIT_W-1:0]   s1_data;
    logic [`FLIT_W-1:0]   swapped;

    assign in_ready = (state == DATA);

    // Valid bytes in the incoming flit.
    always_comb begin
        if (in_eop) begin
            flit_len = LEN_W'(`FLIT_BYTES) - LEN_W'(in_empty);
        end else begin
            flit_len = LEN_W'(`FLIT_BYTES);
        end
    end

    always_comb begin
        hdr.byte_len  = byte_cnt;
        hdr.pdu_id    = pdu_id;
        hdr.tuple     = meta.tuple;
        hdr.host_addr = HOST_W'(meta.host_addr);
    end

    // Byte 0 of the flit ends up in the top byte.
    always_comb begin
        for (int i = 0; i < `FLIT_BYTES; i++) begin
            swapped[8*i +: 8] = s1_data[`FLIT_W-8-8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            s1_wr        <= 1'b0;
            meta_ready   <= 1'b0;
            update_valid <= 1'b0;
            pdu_id       <= '0;
        end else begin
            s1_wr        <= 1'b0;
            meta_ready   <= 1'b0;
            update_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (meta_valid && base_valid && !almost_full) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (in_valid) begin
                        s1_wr <= 1'b1;
                        if (in_eop) begin
                            state <= HEAD;
                        end
                    end
                end
                HEAD: begin
                    s1_wr        <= 1'b1;
                    meta_ready   <= 1'b1;
                    update_valid <= 1'b1;
                    pdu_id       <= pdu_id + 1'b1;
                    state        <= HOLD;
                end
                HOLD: begin
                    // base_valid is stale while the update is in flight.
                    if (base_valid && !update_valid) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && in_valid) begin
            s1_data <= in_data;
            s1_swap <= 1'b1;
            s1_sop  <= 1'b0;
            s1_eop  <= in_eop;
            if (in_sop) begin
                s1_addr  <= base_addr + 1'b1;
                flit_cnt <= RING_AW_ONE;
                byte_cnt <= flit_len;
            end else begin
                s1_addr  <= s1_addr + 1'b1;
                flit_cnt <= flit_cnt + 1'b1;
                byte_cnt <= byte_cnt + flit_len;
            end
        end else if (state == HEAD) begin
            s1_data     <= hdr;
            s1_swap     <= 1'b0;
            s1_sop      <= 1'b1;
            s1_eop      <= 1'b0;
            s1_addr     <= base_addr;
            // One more slot for the header.
            update_size <= flit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= s1_wr;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr     <= s1_addr;
        wr_flit.sop <= s1_sop;
        wr_flit.eop <= s1_eop;
        if (s1_swap) begin
            wr_flit.data <= swapped;
        end else begin
            wr_flit.data <= s1_data;
        end
    end

endmodule

//--- logic/pdu_top.sv
`timescale 1ns/1ns
`include "pdu_defines.svh"

module pdu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic                in_sop,
    input  logic                in_eop,
    input  logic [`FLIT_W-1:0]  in_data,
    input  logic [`EMPTY_W-1:0] in_empty,
    output logic                in_ready,
    input  logic                meta_valid,
    input  pdu_pkg::meta_t      meta,
    output logic                meta_ready,
    input  logic                free_req,
    input  logic [`RING_AW:0]   free_count,
    output logic                free_ack,
    input  logic [`RING_AW-1:0] rd_addr,
    output pdu_pkg::flit_t      rd_flit
);
    import pdu_pkg::*;

    logic [`RING_AW-1:0] base_addr;
    logic                base_valid;
    logic                almost_full;
    logic                update_valid;
    logic [`RING_AW-1:0] update_size;
    logic                wr_en;
    logic [`RING_AW-1:0] wr_addr;
    flit_t               wr_flit;

    pdu_gen u_pdu_gen (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_sop       (in_sop),
        .in_eop       (in_eop),
        .in_data      (in_data),
        .in_empty     (in_empty),
        .in_ready     (in_ready),
        .meta_valid   (meta_valid),
        .meta         (meta),
        .meta_ready   (meta_ready),
        .base_addr    (base_addr),
        .base_valid   (base_valid),
        .almost_full  (almost_full),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_flit      (wr_flit),
        .update_valid (update_valid),
        .update_size  (update_size)
    );

    ring_ctrl u_ring_ctrl (
        .clk          (clk),
        .rst          (rst),
        .update_valid (update_valid),
        .update_size  (update_size),
        .base_addr    (base_addr),
        .base_valid   (base_valid),
        .almost_full  (almost_full),
        .free_req     (free_req),
        .free_count   (free_count),
        .free_ack     (free_ack)
    );

    ring_mem u_ring_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_flit (wr_flit),
        .rd_addr (rd_addr),
        .rd_flit (rd_flit)
    );

endmodule

//--- testbench/pdu_checker.sv
`timescale 1ns/1ns

module pdu_checker (
    input logic clk,
    input logic rst,
    input logic in_ready,
    input logic meta_valid,
    input logic meta_ready,
    input logic update_valid,
    input logic free_req,
    input logic free_ack,
    input logic wr_en,
    input logic wr_sop,
    input logic wr_eop
);

    // Flits are taken only while a PDU's metadata is on offer.
    in_ready_in_pdu: assert property (@(posedge clk) disable iff (rst)
        in_ready |-> meta_valid)
        else $error("in_ready high outside a PDU");

    meta_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        meta_ready |=> !meta_ready)
        else $error("meta_ready held for more than one cycle");

    update_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        update_valid |=> !update_valid)
        else $error("update_valid held for more than one cycle");

    // Four-phase free exchange.
    free_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(free_ack) |-> $past(free_req))
        else $error("free_ack rose without free_req");

    free_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(free_ack) |-> !$past(free_req))
        else $error("free_ack fell while free_req was still high");

    // Header goes out the cycle after the last data flit.
    header_after_eop: assert property (@(posedge clk) disable iff (rst)
        (wr_en && wr_eop) |=> (wr_en && wr_sop))
        else $error("header not written right after the last data flit");

endmodule

bind pdu_top pdu_checker u_pdu_checker (
    .clk          (clk),
    .rst          (rst),
    .in_ready     (in_ready),
    .meta_valid   (meta_valid),
    .meta_ready   (meta_ready),
    .update_valid (update_valid),
    .free_req     (free_req),
    .free_ack     (free_ack),
    .wr_en        (wr_en),
    .wr_sop       (wr_flit.sop),
    .wr_eop       (wr_flit.eop)
);

//--- testbench/pdu_tb.sv
`timescale 1ns/1ns
`include "pdu_defines.svh"

module pdu_tb;
    import pdu_pkg::*;

    localparam int NUM_PKT      = 16;
    localparam int CNT_W        = `RING_AW + 1;
    localparam int RING_DEPTH   = 1 << `RING_AW;
    localparam int EMPTY_W      = `EMPTY_W;
    localparam int STALL_CYCLES = 20;
    localparam int LIMIT_CYCLES = NUM_PKT * 200 + 50;

    typedef struct packed {
        logic [7:0]  len;
        tuple_t      tuple;
        logic [31:0] host;
        logic        free_after;
    } pkt_entry_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                in_valid;
    logic                in_sop;
    logic                in_eop;
    logic [`FLIT_W-1:0]  in_data;
    logic [EMPTY_W-1:0]  in_empty;
    logic                in_ready;
    logic                meta_valid;
    meta_t               meta;
    logic                meta_ready;
    logic                free_req;
    logic [CNT_W-1:0]    free_count;
    logic                free_ack;
    logic [`RING_AW-1:0] rd_addr;
    flit_t               rd_flit;

    pkt_entry_t          pkts [NUM_PKT];
    logic [`RING_AW-1:0] model_base;
    int                  model_free;
    int                  model_id;
    logic [31:0]         lcg_state;
    int                  err_count;

    pdu_top DUT (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte 0 sits in the low bits of a flit.
    function automatic logic [`FLIT_W-1:0] reverse_bytes(input logic [`FLIT_W-1:0] d);
        logic [`FLIT_W-1:0] r;
        for (int b = 0; b < `FLIT_BYTES; b++) begin
            r[8*(`FLIT_BYTES-1-b) +: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    // Lengths cover every empty-byte value on the last flit.
    task automatic load_table();
        pkts[0]  = '{8'd1,   96'hc0a80001_c0a80002_1388_0050, 32'h1000_0000, 1'b0};
        pkts[1]  = '{8'd16,  96'hc0a80003_0a000001_1389_01bb, 32'h1000_0040, 1'b0};
        pkts[2]  = '{8'd127, 96'h0a000002_0a000003_d431_0035, 32'h2000_1080, 1'b0};
        pkts[3]  = '{8'd34,  96'hac100001_ac100002_ffff_0001, 32'h3000_20c0, 1'b0};
        pkts[4]  = '{8'd30,  96'h7f000001_7f000001_0016_c350, 32'h4000_3100, 1'b0};
        pkts[5]  = '{8'd99,  96'h01020304_05060708_090a_0b0c, 32'h5000_4140, 1'b0};
        pkts[6]  = '{8'd13,  96'hdeadbeef_cafef00d_1234_5678, 32'h6000_5180, 1'b0};
        pkts[7]  = '{8'd68,  96'h11111111_22222222_3333_4444, 32'h7000_61c0, 1'b0};
        pkts[8]  = '{8'd60,  96'h55555555_66666666_7777_8888, 32'h8000_7200, 1'b0};
        pkts[9]  = '{8'd5,   96'h99999999_aaaaaaaa_bbbb_cccc, 32'h9000_8240, 1'b0};
        pkts[10] = '{8'd91,  96'hdddddddd_eeeeeeee_ffff_0000, 32'ha000_9280, 1'b0};
        pkts[11] = '{8'd118, 96'h0badf00d_feedface_0bad_beef, 32'hb000_a2c0, 1'b0};
        pkts[12] = '{8'd42,  96'h8badf00d_00c0ffee_c0de_d00d, 32'hc000_b300, 1'b0};
        pkts[13] = '{8'd71,  96'h12345678_9abcdef0_1357_2468, 32'hd000_c340, 1'b0};
        pkts[14] = '{8'd25,  96'h0f0f0f0f_f0f0f0f0_00ff_ff00, 32'he000_d380, 1'b0};
        pkts[15] = '{8'd104, 96'ha5a5a5a5_5a5a5a5a_a5a5_5a5a, 32'hf000_e3c0, 1'b1};
    endtask

    task automatic read_slot(input logic [`RING_AW-1:0] a, output flit_t f);
        rd_addr = a;
        @(posedge clk);
        #1;
        f = rd_flit;
    endtask

    // Hand every used slot back to the ring.
    task automatic return_space();
        int n;
        n = RING_DEPTH - model_free;
        free_count = CNT_W'(n);
        free_req = 1'b1;
        // The ack follows each edge of the request by one cycle.
        @(posedge clk);
        #1;
        check_value("free_ack", free_ack, 1'b1);
        free_req = 1'b0;
        @(posedge clk);
        #1;
        check_value("free_ack", free_ack, 1'b0);
        model_free = model_free + n;
    endtask

    task automatic expect_stall();
        repeat (STALL_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("in_ready", in_ready, 1'b0);
            check_value("meta_ready", meta_ready, 1'b0);
        end
    endtask

    task automatic run_pdu(input int idx);
        pkt_entry_t          e;
        int                  nflits;
        int                  left;
        logic [`FLIT_W-1:0]  flits [`MAX_PDU_FLITS];
        logic [`FLIT_W-1:0]  word;
        logic [`RING_AW-1:0] addr;
        flit_t               got;
        pdu_hdr_t            hdr;
        e = pkts[idx];
        nflits = (int'(e.len) + `FLIT_BYTES - 1) / `FLIT_BYTES;
        meta.tuple = e.tuple;
        meta.host_addr = e.host;
        meta_valid = 1'b1;
        for (int f = 0; f < nflits; f++) begin
            left = int'(e.len) - f * `FLIT_BYTES;
            for (int w = 0; w < `FLIT_W / 32; w++) begin
                lcg_state = lcg_next(lcg_state);
                word[32*w +: 32] = lcg_state;
            end
            for (int b = 0; b < `FLIT_BYTES; b++) begin
                if (b >= left) begin
                    word[8*b +: 8] = 8'h00;
                end
            end
            flits[f] = word;
            in_valid = 1'b1;
            in_sop = (f == 0);
            in_eop = (f == nflits - 1);
            in_empty = in_eop ? EMPTY_W'(`FLIT_BYTES - left) : '0;
            in_data = word;
            // Not enough room for a full PDU.
            if (f == 0 && model_free < `MAX_PDU_FLITS) begin
                expect_stall();
                return_space();
            end
            while (!in_ready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_sop = 1'b0;
        in_eop = 1'b0;
        while (!meta_ready) begin
            @(posedge clk);
            #1;
        end
        meta_valid = 1'b0;
        // Header lands two cycles after meta_ready.
        repeat (2) @(posedge clk);
        #1;
        read_slot(model_base, got);
        hdr = got.data;
        check_value("hdr sop", got.sop, 1'b1);
        check_value("hdr eop", got.eop, 1'b0);
        check_value("hdr byte_len", hdr.byte_len, e.len);
        check_value("hdr pdu_id", hdr.pdu_id, `PDU_ID_W'(model_id));
        check_value("hdr tuple", hdr.tuple, e.tuple);
        check_value("hdr host_addr", hdr.host_addr, e.host[`HOST_HDR_W-1:0]);
        for (int f = 0; f < nflits; f++) begin
            addr = model_base + `RING_AW'(f + 1);
            read_slot(addr, got);
            check_value($sformatf("slot %0d sop", addr), got.sop, 1'b0);
            check_value($sformatf("slot %0d eop", addr), got.eop, f == nflits - 1);
            check_value($sformatf("slot %0d data", addr), got.data,
                        reverse_bytes(flits[f]));
        end
        model_base = model_base + `RING_AW'(nflits + 1);
        model_free = model_free - (nflits + 1);
        model_id++;
        if (e.free_after) begin
            return_space();
        end
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_sop = 1'b0;
        in_eop = 1'b0;
        in_data = '0;
        in_empty = '0;
        meta_valid = 1'b0;
        meta = '0;
        free_req = 1'b0;
        free_count = '0;
        rd_addr = '0;
        lcg_state = 32'h78b7;
        model_base = '0;
        model_free = RING_DEPTH;
        model_id = 0;
        err_count = 0;
        load_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_PKT; i++) begin
            run_pdu(i);
        end
        repeat (4) @(posedge clk);
        if (err_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "%0d checks failed", err_count);
        end
    end

endmodule

//--- pdu_capture.f
+incdir+logic
logic/pdu_pkg.sv
logic/ring_mem.sv
logic/ring_ctrl.sv
logic/pdu_gen.sv
logic/pdu_top.sv
testbench/pdu_checker.sv
testbench/pdu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pdu_tb -f pdu_capture.f

out=$(./obj_dir/Vpdu_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
